// File: design/mips_pkg.sv
package mips_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////////////////////
    typedef logic [31:0] word_t;     // Data or address word
    typedef logic [4:0]  reg_addr_t; // Register index
    typedef logic [3:0]  alu_op_t;

    // ALU operations
    localparam alu_op_t ALU_ADD = 4'd0;
    localparam alu_op_t ALU_SUB = 4'd1;
    localparam alu_op_t ALU_SLT = 4'd2; // Signed compare giving 0 or 1
    localparam alu_op_t ALU_AND = 4'd3;
    localparam alu_op_t ALU_OR  = 4'd4;
    localparam alu_op_t ALU_XOR = 4'd5;
    localparam alu_op_t ALU_SLL = 4'd6;
    localparam alu_op_t ALU_SRL = 4'd7;
    localparam alu_op_t ALU_LUI = 4'd8; // Operand 2 moved to upper half

    ////////////////////////////////////////////////////////////////////////////
    // Opcode and function fields
    ////////////////////////////////////////////////////////////////////////////
    localparam logic [5:0] OP_SPECIAL = 6'b000000; // R-type decoded by funct
    localparam logic [5:0] OP_J       = 6'b000010;
    localparam logic [5:0] OP_JAL     = 6'b000011;
    localparam logic [5:0] OP_BEQ     = 6'b000100;
    localparam logic [5:0] OP_BNE     = 6'b000101;
    localparam logic [5:0] OP_ADDI    = 6'b001000;
    localparam logic [5:0] OP_ADDIU   = 6'b001001;
    localparam logic [5:0] OP_SLTI    = 6'b001010;
    localparam logic [5:0] OP_ANDI    = 6'b001100;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_XORI    = 6'b001110;
    localparam logic [5:0] OP_LUI     = 6'b001111;
    localparam logic [5:0] OP_LW      = 6'b100011;
    localparam logic [5:0] OP_SW      = 6'b101011;

    localparam logic [5:0] FN_SLL  = 6'b000000;
    localparam logic [5:0] FN_SRL  = 6'b000010;
    localparam logic [5:0] FN_JR   = 6'b001000;
    localparam logic [5:0] FN_ADD  = 6'b100000;
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUB  = 6'b100010;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_SLT  = 6'b101010;
    localparam logic [5:0] FN_SLTU = 6'b101011;

    localparam reg_addr_t RA_REG = 5'd31; // Link register for JAL

    // One instruction walks through these in order
    typedef enum logic [2:0] {
        PH_FETCH,
        PH_DECODE,
        PH_EXECUTE,
        PH_MEMORY,
        PH_WRITEBACK
    } phase_e;

    // Decoder control word
    typedef struct packed {
        alu_op_t   alu_op;
        logic      imm_op2;    // Immediate replaces rt as operand 2
        logic      zero_ext;   // Logical immediates
        logic      is_branch;
        logic      branch_ne;  // BNE when set, BEQ otherwise
        logic      is_jump;    // J and JAL
        logic      is_jal;
        logic      is_jr;
        logic      mem_write;
        logic      mem_to_reg; // Load data goes to the register file
        logic      reg_write;
        reg_addr_t dest;       // Already resolved to rd, rt or r31
    } ctrl_t;

    // Execute phase result
    typedef struct packed {
        word_t result;     // ALU result or link address
        word_t store_data; // rt value for SW
        logic  redirect;   // Taken branch or any jump
        word_t target;
    } ex_result_t;

endpackage

// File: design/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit #(
    parameter int IMEM_WORDS = 256
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            load_en,
    input  mips_pkg::word_t load_addr,  // Byte address
    input  mips_pkg::word_t load_data,
    input  logic            advance,    // End of writeback
    input  logic            redirect,
    input  mips_pkg::word_t target,
    output mips_pkg::word_t pc,
    output mips_pkg::word_t insn
);
    localparam int IW = $clog2(IMEM_WORDS);

    mips_pkg::word_t imem [IMEM_WORDS];
    mips_pkg::word_t pc_plus4;

    assign pc_plus4 = pc + 32'd4;

    // Instruction word stays valid while the PC holds
    assign insn = imem[pc[IW+1:2]];

    // Load port writes one word per cycle
    always_ff @(posedge clk) begin
        if (load_en) begin
            imem[load_addr[IW+1:2]] <= load_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (load_en) begin
            pc <= '0; // Program starts at address 0
        end else if (advance) begin
            pc <= redirect ? target : pc_plus4;
        end
    end

endmodule

// File: design/insn_decoder.sv
`timescale 1ns/1ps

module insn_decoder (
    input  mips_pkg::word_t     insn,
    output mips_pkg::reg_addr_t rs,
    output mips_pkg::reg_addr_t rt,
    output mips_pkg::word_t     imm,
    output logic [4:0]          shamt,
    output mips_pkg::ctrl_t     ctrl,
    output logic                illegal
);
    logic [5:0]          opcode;
    logic [5:0]          funct;
    logic [15:0]         imm16;
    mips_pkg::reg_addr_t rd;

    // Field split
    assign opcode = insn[31:26];
    assign rs     = insn[25:21];
    assign rt     = insn[20:16];
    assign rd     = insn[15:11];
    assign shamt  = insn[10:6];
    assign funct  = insn[5:0];
    assign imm16  = insn[15:0];

    // Logical immediates take zeros, all others the sign bit
    assign imm = ctrl.zero_ext ? {16'h0000, imm16} : {{16{imm16[15]}}, imm16};

    always_comb begin
        ctrl      = '0;  // Unknown encodings stay a no-op
        illegal   = 1'b0;
        ctrl.dest = rt;  // I-type default
        case (opcode)
            mips_pkg::OP_SPECIAL: begin
                ctrl.dest      = rd;
                ctrl.reg_write = 1'b1;
                case (funct)
                    mips_pkg::FN_ADD, mips_pkg::FN_ADDU:
                        ctrl.alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUB, mips_pkg::FN_SUBU:
                        ctrl.alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::FN_SLT, mips_pkg::FN_SLTU:
                        ctrl.alu_op = mips_pkg::ALU_SLT; // Both use the signed compare
                    mips_pkg::FN_SLL: ctrl.alu_op = mips_pkg::ALU_SLL;
                    mips_pkg::FN_SRL: ctrl.alu_op = mips_pkg::ALU_SRL;
                    mips_pkg::FN_JR: begin
                        ctrl.is_jr     = 1'b1;
                        ctrl.reg_write = 1'b0;
                    end
                    default: begin
                        ctrl.reg_write = 1'b0;
                        illegal        = 1'b1;
                    end
                endcase
            end

            // Jumps
            mips_pkg::OP_J: ctrl.is_jump = 1'b1;
            mips_pkg::OP_JAL: begin
                ctrl.is_jump   = 1'b1;
                ctrl.is_jal    = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.dest      = mips_pkg::RA_REG;
            end

            // Branches compare rs and rt directly in execute
            mips_pkg::OP_BEQ: ctrl.is_branch = 1'b1;
            mips_pkg::OP_BNE: begin
                ctrl.is_branch = 1'b1;
                ctrl.branch_ne = 1'b1;
            end

            mips_pkg::OP_ADDI, mips_pkg::OP_ADDIU, mips_pkg::OP_SLTI,
            mips_pkg::OP_ANDI, mips_pkg::OP_ORI, mips_pkg::OP_XORI,
            mips_pkg::OP_LUI: begin
                ctrl.imm_op2   = 1'b1;
                ctrl.reg_write = 1'b1;
                case (opcode)
                    mips_pkg::OP_SLTI: ctrl.alu_op = mips_pkg::ALU_SLT;
                    mips_pkg::OP_ANDI: ctrl.alu_op = mips_pkg::ALU_AND;
                    mips_pkg::OP_ORI:  ctrl.alu_op = mips_pkg::ALU_OR;
                    mips_pkg::OP_XORI: ctrl.alu_op = mips_pkg::ALU_XOR;
                    mips_pkg::OP_LUI:  ctrl.alu_op = mips_pkg::ALU_LUI;
                    default:           ctrl.alu_op = mips_pkg::ALU_ADD;
                endcase
                ctrl.zero_ext = (opcode == mips_pkg::OP_ANDI) ||
                                (opcode == mips_pkg::OP_ORI)  ||
                                (opcode == mips_pkg::OP_XORI);
            end

            // Address is rs plus offset
            mips_pkg::OP_LW: begin
                ctrl.imm_op2    = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.reg_write  = 1'b1;
            end
            mips_pkg::OP_SW: begin
                ctrl.imm_op2   = 1'b1;
                ctrl.mem_write = 1'b1;
            end

            default: illegal = 1'b1;
        endcase
    end

endmodule

// File: design/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                clk,
    input  logic                rst_n,
    input  mips_pkg::reg_addr_t rs,
    input  mips_pkg::reg_addr_t rt,
    input  logic                we,
    input  mips_pkg::reg_addr_t waddr,
    input  mips_pkg::word_t     wdata,
    output mips_pkg::word_t     rs_val,
    output mips_pkg::word_t     rt_val
);
    mips_pkg::word_t regs [32];

    // r0 is wired to zero on the read side
    assign rs_val = (rs == '0) ? '0 : regs[rs];
    assign rt_val = (rt == '0) ? '0 : regs[rt];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin // Writes to r0 dropped
            regs[waddr] <= wdata;
        end
    end

endmodule

// File: design/execute_unit.sv
`timescale 1ns/1ps

module execute_unit (
    input  mips_pkg::ctrl_t      ctrl,
    input  mips_pkg::word_t      pc,
    input  mips_pkg::word_t      a,        // rs value
    input  mips_pkg::word_t      b,        // rt value
    input  mips_pkg::word_t      imm,
    input  logic [4:0]           shamt,
    input  logic [25:0]          target26,
    output mips_pkg::ex_result_t ex
);
    mips_pkg::word_t op2;
    mips_pkg::word_t alu_result;
    mips_pkg::word_t pc_plus4;
    mips_pkg::word_t branch_target;
    mips_pkg::word_t jump_target;
    logic            taken;

    assign op2 = ctrl.imm_op2 ? imm : b;

    ////////////////////////////////////////////////////////////////////////////
    // ALU
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        case (ctrl.alu_op)
            mips_pkg::ALU_ADD: alu_result = a + op2;
            mips_pkg::ALU_SUB: alu_result = a - op2;
            mips_pkg::ALU_SLT: alu_result = {31'b0, $signed(a) < $signed(op2)};
            mips_pkg::ALU_AND: alu_result = a & op2;
            mips_pkg::ALU_OR:  alu_result = a | op2;
            mips_pkg::ALU_XOR: alu_result = a ^ op2;
            mips_pkg::ALU_SLL: alu_result = b << shamt; // Shifts always on rt
            mips_pkg::ALU_SRL: alu_result = b >> shamt;
            mips_pkg::ALU_LUI: alu_result = {op2[15:0], 16'h0000};
            default:           alu_result = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Branch and jump resolution
    ////////////////////////////////////////////////////////////////////////////
    assign pc_plus4      = pc + 32'd4;
    assign branch_target = pc_plus4 + {imm[29:0], 2'b00};  // Word offset
    assign jump_target   = {pc_plus4[31:28], target26, 2'b00}; // Same 256 MB region

    assign taken = ctrl.is_branch && (ctrl.branch_ne ? (a != b) : (a == b));

    always_comb begin
        ex.result     = ctrl.is_jal ? pc_plus4 : alu_result; // Link value for JAL
        ex.store_data = b;
        ex.redirect   = taken || ctrl.is_jump || ctrl.is_jr;
        if (ctrl.is_jr) begin
            ex.target = a;
        end else if (ctrl.is_jump) begin
            ex.target = jump_target;
        end else begin
            ex.target = branch_target;
        end
    end

endmodule

// File: design/data_memory.sv
`timescale 1ns/1ps

module data_memory #(
    parameter int DMEM_WORDS = 256
) (
    input  logic            clk,
    input  logic            we,
    input  mips_pkg::word_t addr,  // Byte address with low bits ignored
    input  mips_pkg::word_t wdata,
    output mips_pkg::word_t rdata
);
    localparam int AW = $clog2(DMEM_WORDS);

    mips_pkg::word_t mem [DMEM_WORDS];
    logic [AW-1:0]   idx;

    assign idx = addr[AW+1:2]; // Word index

    // Read is combinational for the LW in the memory phase
    assign rdata = mem[idx];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[idx] <= wdata;
        end
    end

endmodule

// File: design/mips_multicycle.sv
`timescale 1ns/1ps

module mips_multicycle #(
    parameter int IMEM_WORDS = 256,
    parameter int DMEM_WORDS = 256
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                load_en,
    input  mips_pkg::word_t     load_addr,
    input  mips_pkg::word_t     load_data,
    output mips_pkg::word_t     pc,
    output logic                retire,
    output logic                reg_we,
    output mips_pkg::reg_addr_t reg_addr,
    output mips_pkg::word_t     reg_data,
    output logic                illegal
);
    mips_pkg::phase_e     phase;
    mips_pkg::word_t      insn;
    mips_pkg::reg_addr_t  rs;
    mips_pkg::reg_addr_t  rt;
    mips_pkg::word_t      imm;
    logic [4:0]           shamt;
    mips_pkg::ctrl_t      ctrl_d;
    mips_pkg::ctrl_t      ctrl_q;
    logic                 dec_illegal;
    mips_pkg::word_t      rs_val;
    mips_pkg::word_t      rt_val;
    mips_pkg::ex_result_t ex_d;
    mips_pkg::ex_result_t ex_q;
    mips_pkg::word_t      mem_rdata;
    mips_pkg::word_t      wb_data_q;

    ////////////////////////////////////////////////////////////////////////////
    // Phase sequencer
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= mips_pkg::PH_FETCH;
        end else if (load_en) begin
            phase <= mips_pkg::PH_FETCH; // Held while memory is loaded
        end else begin
            case (phase)
                mips_pkg::PH_FETCH:   phase <= mips_pkg::PH_DECODE;
                mips_pkg::PH_DECODE:  phase <= mips_pkg::PH_EXECUTE;
                mips_pkg::PH_EXECUTE: phase <= mips_pkg::PH_MEMORY;
                mips_pkg::PH_MEMORY:  phase <= mips_pkg::PH_WRITEBACK;
                default:              phase <= mips_pkg::PH_FETCH;
            endcase
        end
    end

    // Insn stays stable until the PC moves at the end of writeback
    fetch_unit #(.IMEM_WORDS(IMEM_WORDS)) i_fetch (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .advance   (phase == mips_pkg::PH_WRITEBACK),
        .redirect  (ex_q.redirect),
        .target    (ex_q.target),
        .pc        (pc),
        .insn      (insn)
    );

    insn_decoder i_decoder (
        .insn    (insn),
        .rs      (rs),
        .rt      (rt),
        .imm     (imm),
        .shamt   (shamt),
        .ctrl    (ctrl_d),
        .illegal (dec_illegal)
    );

    reg_file i_regs (
        .clk    (clk),
        .rst_n  (rst_n),
        .rs     (rs),
        .rt     (rt),
        .we     (reg_we),
        .waddr  (reg_addr),
        .wdata  (reg_data),
        .rs_val (rs_val),
        .rt_val (rt_val)
    );

    execute_unit i_execute (
        .ctrl     (ctrl_q),
        .pc       (pc),
        .a        (rs_val),
        .b        (rt_val),
        .imm      (imm),
        .shamt    (shamt),
        .target26 (insn[25:0]),
        .ex       (ex_d)
    );

    // Store lands on the edge that closes the memory phase
    data_memory #(.DMEM_WORDS(DMEM_WORDS)) i_dmem (
        .clk   (clk),
        .we    (phase == mips_pkg::PH_MEMORY && ctrl_q.mem_write),
        .addr  (ex_q.result),
        .wdata (ex_q.store_data),
        .rdata (mem_rdata)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Phase registers
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_q <= '0;
            ex_q   <= '0;
        end else begin
            if (phase == mips_pkg::PH_DECODE)  ctrl_q <= ctrl_d;
            if (phase == mips_pkg::PH_EXECUTE) ex_q   <= ex_d;
        end
    end

    // Writeback mux picks load data or ALU result
    always_ff @(posedge clk) begin
        if (phase == mips_pkg::PH_MEMORY) begin
            wb_data_q <= ctrl_q.mem_to_reg ? mem_rdata : ex_q.result;
        end
    end

    assign retire   = (phase == mips_pkg::PH_WRITEBACK);
    assign reg_we   = retire && ctrl_q.reg_write && (ctrl_q.dest != '0);
    assign reg_addr = ctrl_q.dest;
    assign reg_data = wb_data_q;
    assign illegal  = (phase == mips_pkg::PH_DECODE) && dec_illegal; // One pulse per insn

endmodule

// File: tb/mips_assertions.sv
`timescale 1ns/1ps

module mips_assertions (
    input logic                clk,
    input logic                rst_n,
    input logic                load_en,
    input logic                retire,
    input logic                reg_we,
    input mips_pkg::reg_addr_t reg_addr,
    input logic                illegal
);
    int fail_count = 0; // Failure tally

    ////////////////////////////////////////////////////////////////////////////
    // Sequencing and writeback rules
    ////////////////////////////////////////////////////////////////////////////
    // Five phases per instruction
    property retire_every_five;
        @(posedge clk) disable iff (!rst_n || load_en)
            retire |=> !retire [*4] ##1 retire;
    endproperty

    property no_write_to_r0;
        @(posedge clk) disable iff (!rst_n)
            reg_we |-> reg_addr != '0;
    endproperty

    // Decode to writeback is three edges
    property illegal_never_writes;
        @(posedge clk) disable iff (!rst_n)
            illegal |-> ##3 (retire && !reg_we);
    endproperty

    retire_rhythm: assert property (retire_every_five)
        else begin
            fail_count++;
            $error("retire did not repeat exactly 5 cycles later");
        end

    r0_protect: assert property (no_write_to_r0)
        else begin
            fail_count++;
            $error("reg_we raised with reg_addr 0");
        end

    illegal_nop: assert property (illegal_never_writes)
        else begin
            fail_count++;
            $error("illegal instruction wrote a register at retire");
        end

endmodule

bind mips_multicycle mips_assertions i_checks (.*);

// File: tb/tb_mips_multicycle.sv
`timescale 1ns/1ps

module tb_mips_multicycle;

    localparam int              PROG_LEN   = 24;
    localparam int              MAX_CYCLES = 5 * PROG_LEN + 60; // Counted once load ends
    localparam time             SKEW       = 10ns;              // Drive delay after posedge
    localparam mips_pkg::word_t ILLEGAL_PC = 32'd84;
    localparam mips_pkg::word_t HALT_PC    = 32'd92;            // BEQ r0,r0,-1 self loop

    logic                clk;
    logic                rst_n;
    logic                load_en;
    mips_pkg::word_t     load_addr;
    mips_pkg::word_t     load_data;
    mips_pkg::word_t     pc;
    logic                retire;
    logic                reg_we;
    mips_pkg::reg_addr_t reg_addr;
    mips_pkg::word_t     reg_data;
    logic                illegal;

    mips_pkg::word_t     prog [PROG_LEN];
    mips_pkg::reg_addr_t exp_reg [15];     // Register writes in program order
    mips_pkg::word_t     exp_val [15];
    mips_pkg::word_t     flow_from [5];    // PC of a branch or jump
    mips_pkg::word_t     flow_to [5];      // PC expected right after it
    mips_pkg::word_t     test_end [5] = '{32'd36, 32'd44, 32'd60, 32'd72, 32'd88};
    string               test_name [5] = '{"alu", "memory", "branch", "jump", "illegal_r0"};
    mips_pkg::word_t     pc_want;
    int                  seed = 43;
    int                  exp_idx = 0;
    int                  errors = 0;
    int                  err_mark = 0;
    int                  tests_run = 0;
    int                  tests_failed = 0;
    int                  next_test = 0;
    int                  cycles = 0;
    logic                pc_check_due = 1'b0;
    logic                report_due = 1'b0;
    logic                illegal_seen = 1'b0;
    logic                halted = 1'b0;

    mips_multicycle i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50ns clk = ~clk; // 100 ns period
    end

    ////////////////////////////////////////////////////////////////////////////
    // Program builder
    ////////////////////////////////////////////////////////////////////////////
    function automatic mips_pkg::word_t r_format(input logic [4:0] rs, input logic [4:0] rt,
                                                 input logic [4:0] rd, input logic [4:0] sa,
                                                 input logic [5:0] fn);
        return {mips_pkg::OP_SPECIAL, rs, rt, rd, sa, fn};
    endfunction

    function automatic mips_pkg::word_t i_format(input logic [5:0] op, input logic [4:0] rs,
                                                 input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic build_program();
        mips_pkg::word_t rnd_a;
        mips_pkg::word_t rnd_b;
        mips_pkg::word_t a;
        mips_pkg::word_t b;
        mips_pkg::word_t c;
        mips_pkg::word_t a_lt_b;
        rnd_a = $random(seed);
        rnd_b = $random(seed);
        a = {{16{rnd_a[15]}}, rnd_a[15:0]}; // ADDI sign-extends
        b = {16'h0000, rnd_b[15:0]};        // ORI zero-extends
        c = 32'h1234_0000;
        a_lt_b = (a[31] || a < b) ? 32'd1 : 32'd0; // b is never negative
        prog = '{
            i_format(mips_pkg::OP_ADDI, 5'd0, 5'd1, rnd_a[15:0]),  // 0x00 r1 = a
            i_format(mips_pkg::OP_ORI, 5'd0, 5'd2, rnd_b[15:0]),   // r2 = b
            i_format(mips_pkg::OP_LUI, 5'd0, 5'd3, 16'h1234),      // r3 = c
            r_format(5'd1, 5'd2, 5'd4, 5'd0, mips_pkg::FN_ADD),
            r_format(5'd1, 5'd2, 5'd5, 5'd0, mips_pkg::FN_SUB),
            r_format(5'd1, 5'd2, 5'd6, 5'd0, mips_pkg::FN_SLT),
            r_format(5'd0, 5'd2, 5'd7, 5'd4, mips_pkg::FN_SLL),
            r_format(5'd0, 5'd3, 5'd8, 5'd8, mips_pkg::FN_SRL),
            i_format(mips_pkg::OP_ANDI, 5'd1, 5'd9, 16'hF0F0),
            i_format(mips_pkg::OP_XORI, 5'd3, 5'd10, 16'hFFFF),
            i_format(mips_pkg::OP_SW, 5'd0, 5'd4, 16'd16),         // 0x28 word 4 = r4
            i_format(mips_pkg::OP_LW, 5'd0, 5'd11, 16'd16),
            i_format(mips_pkg::OP_BEQ, 5'd11, 5'd4, 16'd1),        // 0x30 taken
            i_format(mips_pkg::OP_ADDI, 5'd0, 5'd12, 16'd1),       // Skipped
            i_format(mips_pkg::OP_BNE, 5'd11, 5'd4, 16'd1),        // 0x38 falls through
            i_format(mips_pkg::OP_ADDI, 5'd0, 5'd13, 16'd7),
            {mips_pkg::OP_JAL, 26'd19},                            // 0x40 call 0x4c
            i_format(mips_pkg::OP_ADDI, 5'd0, 5'd14, 16'd9),       // Return lands here
            {mips_pkg::OP_J, 26'd21},                              // 0x48 over the subroutine
            i_format(mips_pkg::OP_ADDI, 5'd0, 5'd15, 16'd3),       // 0x4c subroutine
            r_format(5'd31, 5'd0, 5'd0, 5'd0, mips_pkg::FN_JR),
            {6'h3f, 5'd1, 5'd16, 16'h0005},                        // 0x54 unsupported
            i_format(mips_pkg::OP_ADDI, 5'd0, 5'd0, 16'd5),        // Aimed at r0
            i_format(mips_pkg::OP_BEQ, 5'd0, 5'd0, 16'hFFFF)       // 0x5c halt loop
        };
        exp_reg = '{5'd1, 5'd2, 5'd3, 5'd4, 5'd5, 5'd6, 5'd7, 5'd8, 5'd9, 5'd10,
                    5'd11, 5'd13, 5'd31, 5'd15, 5'd14};
        exp_val = '{a, b, c, a + b, a - b, a_lt_b, b << 4,
                    c >> 8, a & 32'h0000_F0F0, c ^ 32'h0000_FFFF, a + b, 32'd7,
                    32'd68, 32'd3, 32'd9};      // r31 gets PC+4 of the JAL
        flow_from = '{32'd48, 32'd56, 32'd64, 32'd72, 32'd80};
        flow_to   = '{32'd52 + (32'd1 << 2),    // PC+4 plus word offset
                      32'd60,                   // Not taken
                      {4'h0, 26'd19, 2'b00},    // Region bits of PC+4 are zero
                      {4'h0, 26'd21, 2'b00},
                      32'd68};                  // JR back through r31
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Reporting
    ////////////////////////////////////////////////////////////////////////////
    task automatic report_mismatch(input string name, input mips_pkg::word_t want,
                                   input mips_pkg::word_t got);
        $display("[ERROR] %0d ns %s: expected 0x%08h, got 0x%08h", $time, name, want, got);
        errors++;
    endtask

    task automatic note_failure(input string what);
        $display("Error at %0d ns: %s", $time, what);
        errors++;
    endtask

    function automatic int total_errors();
        return errors + i_dut.i_checks.fail_count; // Bound checks count too
    endfunction

    task automatic finish_test(input string name);
        int n;
        n = total_errors() - err_mark;
        err_mark = total_errors();
        tests_run++;
        if (n != 0) tests_failed++;
        $display("Test %-10s %s, %0d errors", name, (n == 0) ? "ok" : "failed", n);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Output monitor sampled mid-cycle
    ////////////////////////////////////////////////////////////////////////////
    always @(negedge clk) begin
        if (pc_check_due) begin
            pc_check_due = 1'b0;
            assert (pc == pc_want) else report_mismatch("pc", pc_want, pc);
        end
        if (report_due) begin // One cycle late so the PC check lands first
            report_due = 1'b0;
            finish_test(test_name[next_test]);
            next_test++;
        end
        if (!rst_n || load_en) begin
            assert (!retire && !reg_we && !illegal)
                else note_failure("retire, reg_we or illegal high in reset or load");
        end
        if (illegal) begin
            illegal_seen = 1'b1;
            assert (pc == ILLEGAL_PC) else report_mismatch("pc", ILLEGAL_PC, pc);
        end
        if (reg_we) begin
            assert (exp_idx < 15) else note_failure("register write beyond the table");
            if (exp_idx < 15) begin
                assert (reg_addr == exp_reg[exp_idx])
                    else report_mismatch("reg_addr", exp_reg[exp_idx], reg_addr);
                assert (reg_data == exp_val[exp_idx])
                    else report_mismatch("reg_data", exp_val[exp_idx], reg_data);
                exp_idx++;
            end
        end
        if (retire) begin
            for (int k = 0; k < 5; k++) begin
                if (pc == flow_from[k]) begin
                    pc_check_due = 1'b1;
                    pc_want      = flow_to[k];
                end
            end
            if (pc == ILLEGAL_PC) begin
                assert (illegal_seen) else note_failure("no illegal pulse for opcode 0x3f");
            end
            if (next_test < 5 && pc == test_end[next_test]) report_due = 1'b1;
            if (pc == HALT_PC) halted = 1'b1;
        end
    end

    // Watchdog
    initial begin
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            if (rst_n && !load_en) cycles++;
        end
        $display("Timeout: halt loop not reached within %0d cycles", MAX_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        rst_n     = 1'b0;
        load_en   = 1'b1; // Sequencer held from the start
        load_addr = '0;
        build_program();
        load_data = prog[0];
        repeat (16) @(posedge clk);
        #SKEW;
        rst_n = 1'b1;
        for (int i = 0; i < PROG_LEN; i++) begin
            load_addr = 32'(i * 4);
            load_data = prog[i];
            @(posedge clk);
            #SKEW;
        end
        load_en = 1'b0;
        assert (pc == '0) else report_mismatch("pc", '0, pc);
        finish_test("reset_load");

        wait (halted);
        @(negedge clk);
        assert (exp_idx == 15) else note_failure("not every expected register write was seen");
        $display("Summary: %0d tests, %0d failed, %0d errors",
                 tests_run, tests_failed, total_errors());
        if (total_errors() == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: mips_multicycle.f
design/mips_pkg.sv
design/fetch_unit.sv
design/insn_decoder.sv
design/reg_file.sv
design/execute_unit.sv
design/data_memory.sv
design/mips_multicycle.sv
tb/mips_assertions.sv
tb/tb_mips_multicycle.sv

// File: Bender.yml
package:
  name: mips_multicycle

sources:
  - design/mips_pkg.sv
  - design/fetch_unit.sv
  - design/insn_decoder.sv
  - design/reg_file.sv
  - design/execute_unit.sv
  - design/data_memory.sv
  - design/mips_multicycle.sv
  - target: test
    files:
      - tb/mips_assertions.sv
      - tb/tb_mips_multicycle.sv
